//--- logic/ecc_sram_settings.svh
`ifndef ECC_SRAM_SETTINGS_SVH
`define ECC_SRAM_SETTINGS_SVH

// Geometry of the Hsiao (39,32) SECDED code
`define ECC_DATA_WIDTH 32
`define ECC_CHECK_WIDTH 7
`define ECC_PROT_WIDTH 39

// One bank of codewords
`define ECC_BANK_SIZE 256
`define ECC_BANK_ADDR_WIDTH 8 // log2 of ECC_BANK_SIZE

`endif

//--- logic/ecc_code_pkg.sv
`default_nettype none

`include "ecc_sram_settings.svh"

package ecc_code_pkg;

  // Verdict of the decoder on one codeword
  typedef enum logic [1:0] {
    ECC_OK     = 2'd0,
    ECC_SINGLE = 2'd1, // Corrected
    ECC_MULTI  = 2'd2  // Detected only
  } ecc_status_e;

  // Column of data bit n in the parity matrix.
  // Weight-3 patterns taken in ascending order, bit n gets the n-th one
  function automatic logic [`ECC_CHECK_WIDTH-1:0] hsiao_column(input int unsigned n);
    logic [`ECC_CHECK_WIDTH-1:0] col;
    int unsigned                 found;
    col   = '0;
    found = 0;
    for (int unsigned v = 0; v < (1 << `ECC_CHECK_WIDTH); v++) begin
      if ($countones(v[`ECC_CHECK_WIDTH-1:0]) == 3) begin
        if (found == n) begin
          col = v[`ECC_CHECK_WIDTH-1:0];
        end
        found++;
      end
    end
    return col;
  endfunction

endpackage

`default_nettype wire

//--- logic/sram_ctrl_pkg.sv
`default_nettype none

package sram_ctrl_pkg;

  // Bus adapter: direct access or second half of a read-modify-write
  typedef enum logic {
    NORMAL         = 1'b0,
    LOAD_AND_STORE = 1'b1
  } store_state_e;

  // Background scrubber
  typedef enum logic [1:0] {
    SCRUB_IDLE  = 2'd0, // Waiting for a free bank cycle
    SCRUB_CHECK = 2'd1, // Read data of the scrub address is on the bank output
    SCRUB_FIX   = 2'd2  // Corrected word waits for a free write slot
  } scrub_state_e;

endpackage

`default_nettype wire

//--- logic/hsiao_encoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "ecc_sram_settings.svh"

module hsiao_encoder (
  input  logic [`ECC_DATA_WIDTH-1:0] data_i,
  output logic [`ECC_PROT_WIDTH-1:0] code_o
);

  logic [`ECC_CHECK_WIDTH-1:0] check;

  // Every set data bit toggles the check bits named by its column
  always_comb begin
    check = '0;
    for (int n = 0; n < `ECC_DATA_WIDTH; n++) begin
      check = check ^ ({`ECC_CHECK_WIDTH{data_i[n]}} & ecc_code_pkg::hsiao_column(n));
    end
  end

  assign code_o = {check, data_i}; // Check bits above the data

endmodule

`default_nettype wire

//--- logic/hsiao_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "ecc_sram_settings.svh"

module hsiao_decoder (
  input  logic [`ECC_PROT_WIDTH-1:0]  code_i,
  output logic [`ECC_DATA_WIDTH-1:0]  data_o,
  output logic [`ECC_CHECK_WIDTH-1:0] syndrome_o,
  output ecc_code_pkg::ecc_status_e   status_o
);

  logic [`ECC_CHECK_WIDTH-1:0] parity;     // Recomputed from the stored data
  logic                        data_hit;   // Syndrome equals a data column
  logic                        check_hit;  // Syndrome is a unit vector
  logic                        odd_weight;

  always_comb begin
    parity = '0;
    for (int n = 0; n < `ECC_DATA_WIDTH; n++) begin
      parity = parity ^ ({`ECC_CHECK_WIDTH{code_i[n]}} & ecc_code_pkg::hsiao_column(n));
    end
  end

  assign syndrome_o = parity ^ code_i[`ECC_PROT_WIDTH-1:`ECC_DATA_WIDTH];
  assign odd_weight = ^syndrome_o;
  assign check_hit  = (syndrome_o != '0) && ((syndrome_o & (syndrome_o - 1'b1)) == '0);

  // Flip the one data bit whose column matches
  always_comb begin
    data_o   = code_i[`ECC_DATA_WIDTH-1:0];
    data_hit = 1'b0;
    for (int n = 0; n < `ECC_DATA_WIDTH; n++) begin
      if (syndrome_o == ecc_code_pkg::hsiao_column(n)) begin
        data_o[n] = ~code_i[n];
        data_hit  = 1'b1;
      end
    end
  end

  // Even weight, or odd weight naming no column, is beyond correction
  always_comb begin
    if (syndrome_o == '0) begin
      status_o = ecc_code_pkg::ECC_OK;
    end else if (odd_weight && (data_hit || check_hit)) begin
      status_o = ecc_code_pkg::ECC_SINGLE;
    end else begin
      status_o = ecc_code_pkg::ECC_MULTI;
    end
  end

  // Distinct columns let a syndrome name at most one data bit
  always_comb begin
    assert final ($countones(data_o ^ code_i[`ECC_DATA_WIDTH-1:0]) <= 1)
      else $error("decoder flips more than one data bit");
  end

endmodule

`default_nettype wire

//--- logic/sram_bank.sv
`timescale 1ns/10ps
`default_nettype none

`include "ecc_sram_settings.svh"

module sram_bank #(
  parameter  int unsigned NumWords  = `ECC_BANK_SIZE,
  parameter  int unsigned DataWidth = `ECC_PROT_WIDTH,
  localparam int unsigned AddrWidth = $clog2(NumWords)
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0] wdata_i,
  output logic [DataWidth-1:0] rdata_o
);

  logic [DataWidth-1:0] mem [NumWords] = '{default: '0}; // Powers up as all zeros

  // Single port, one cycle read latency
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i]; // Held until the next read
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) req_i |-> !$isunknown(addr_i))
    else $error("bank access with unknown address bits");

endmodule

`default_nettype wire

//--- logic/ecc_scrubber.sv
`timescale 1ns/10ps
`default_nettype none

`include "ecc_sram_settings.svh"

module ecc_scrubber (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            scrub_trigger_i,
  input  logic                            intc_req_i,
  input  logic                            intc_we_i,
  input  logic [`ECC_BANK_ADDR_WIDTH-1:0] intc_add_i,
  input  logic [`ECC_PROT_WIDTH-1:0]      intc_wdata_i,
  output logic                            bit_corrected_o,
  output logic                            uncorrectable_o,
  output logic [`ECC_PROT_WIDTH-1:0]      intc_rdata_o
);

  localparam int unsigned          AddrWidth = `ECC_BANK_ADDR_WIDTH;
  localparam logic [AddrWidth-1:0] LastAdd   = AddrWidth'(`ECC_BANK_SIZE - 1);

  sram_ctrl_pkg::scrub_state_e state_d, state_q;

  logic [AddrWidth-1:0]        scrub_add_d, scrub_add_q;
  logic [AddrWidth-1:0]        scrub_add_next;
  logic                        scrub_req;
  logic                        scrub_we;

  logic [`ECC_DATA_WIDTH-1:0]  dec_data;
  ecc_code_pkg::ecc_status_e   dec_status;
  logic [`ECC_DATA_WIDTH-1:0]  fix_data_q; // Corrected word of the scrub address
  logic [`ECC_PROT_WIDTH-1:0]  fix_code;

  logic                        bank_req;
  logic                        bank_we;
  logic [AddrWidth-1:0]        bank_add;
  logic [`ECC_PROT_WIDTH-1:0]  bank_wdata;
  logic [`ECC_PROT_WIDTH-1:0]  bank_rdata;

  assign scrub_add_next = (scrub_add_q == LastAdd) ? '0 : scrub_add_q + 1'b1;

  always_comb begin
    state_d         = state_q;
    scrub_add_d     = scrub_add_q;
    scrub_req       = 1'b0;
    scrub_we        = 1'b0;
    bit_corrected_o = 1'b0;
    uncorrectable_o = 1'b0;
    case (state_q)
      sram_ctrl_pkg::SCRUB_IDLE: begin
        if (scrub_trigger_i && !intc_req_i) begin
          scrub_req = 1'b1;
          state_d   = sram_ctrl_pkg::SCRUB_CHECK;
        end
      end
      sram_ctrl_pkg::SCRUB_CHECK: begin
        if (intc_req_i) begin
          // Bus access may change the word under us, read it again
          state_d = sram_ctrl_pkg::SCRUB_IDLE;
        end else if (dec_status == ecc_code_pkg::ECC_SINGLE) begin
          state_d = sram_ctrl_pkg::SCRUB_FIX;
        end else begin
          uncorrectable_o = (dec_status == ecc_code_pkg::ECC_MULTI);
          scrub_add_d     = scrub_add_next;
          state_d         = sram_ctrl_pkg::SCRUB_IDLE;
        end
      end
      sram_ctrl_pkg::SCRUB_FIX: begin
        if (!intc_req_i) begin
          scrub_req       = 1'b1;
          scrub_we        = 1'b1;
          bit_corrected_o = 1'b1;
          scrub_add_d     = scrub_add_next;
          state_d         = sram_ctrl_pkg::SCRUB_IDLE;
        end else if (intc_we_i && (intc_add_i == scrub_add_q)) begin
          scrub_add_d = scrub_add_next; // Bus data is newer, drop the fix
          state_d     = sram_ctrl_pkg::SCRUB_IDLE;
        end
      end
      default: state_d = sram_ctrl_pkg::SCRUB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= sram_ctrl_pkg::SCRUB_IDLE;
      scrub_add_q <= '0;
    end else begin
      state_q     <= state_d;
      scrub_add_q <= scrub_add_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == sram_ctrl_pkg::SCRUB_CHECK) begin
      fix_data_q <= dec_data;
    end
  end

  // Bus always wins the bank
  assign bank_req     = intc_req_i | scrub_req;
  assign bank_we      = intc_req_i ? intc_we_i    : scrub_we;
  assign bank_add     = intc_req_i ? intc_add_i   : scrub_add_q;
  assign bank_wdata   = intc_req_i ? intc_wdata_i : fix_code;
  assign intc_rdata_o = bank_rdata;

  hsiao_decoder i_scrub_decoder (
    .code_i     (bank_rdata),
    .data_o     (dec_data),
    .syndrome_o (),
    .status_o   (dec_status)
  );

  hsiao_encoder i_scrub_encoder (
    .data_i (fix_data_q),
    .code_o (fix_code)
  );

  sram_bank #(
    .NumWords  (`ECC_BANK_SIZE),
    .DataWidth (`ECC_PROT_WIDTH)
  ) i_bank (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (bank_req),
    .we_i    (bank_we),
    .addr_i  (bank_add),
    .wdata_i (bank_wdata),
    .rdata_o (bank_rdata)
  );

  // A check cycle always follows a bank read of the scrub address
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (state_q == sram_ctrl_pkg::SCRUB_CHECK) |->
                   $past(bank_req && !bank_we && (bank_add == scrub_add_q)))
    else $error("scrub check without a scrub read of its address");

endmodule

`default_nettype wire

//--- logic/ecc_sram_wrap.sv
`timescale 1ns/10ps
`default_nettype none

`include "ecc_sram_settings.svh"

module ecc_sram_wrap (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         scrub_trigger_i, // Low keeps the scrubber parked
  input  logic                         req_i,
  input  logic                         wen_i,           // High for a read
  input  logic [31:0]                  add_i,           // Byte address
  input  logic [`ECC_DATA_WIDTH/8-1:0] be_i,
  input  logic [`ECC_DATA_WIDTH-1:0]   wdata_i,
  input  logic [`ECC_PROT_WIDTH-1:0]   inject_mask_i,   // Set bits flip stored codeword bits
  output logic [`ECC_DATA_WIDTH-1:0]   rdata_o,
  output logic                         gnt_o,
  output logic                         single_error_o,
  output logic                         multi_error_o,
  output logic                         scrubber_fix_o,
  output logic                         scrub_uncorrectable_o
);

  localparam int unsigned NumBytes  = `ECC_DATA_WIDTH / 8;
  localparam int unsigned AddrWidth = `ECC_BANK_ADDR_WIDTH;

  sram_ctrl_pkg::store_state_e store_state_d, store_state_q;

  logic                        accept;
  logic                        full_word;
  logic                        partial_write;
  logic [AddrWidth-1:0]        word_add;
  logic                        read_valid_q;

  // Read-modify-write buffers
  logic [AddrWidth-1:0]        add_buf_q;
  logic [NumBytes-1:0]         be_buf_q;
  logic [`ECC_DATA_WIDTH-1:0]  wdata_buf_q;
  logic [`ECC_PROT_WIDTH-1:0]  mask_buf_q;

  logic [`ECC_DATA_WIDTH-1:0]  be_mask;
  logic [`ECC_DATA_WIDTH-1:0]  merged_data;
  logic [`ECC_DATA_WIDTH-1:0]  enc_data;
  logic [`ECC_PROT_WIDTH-1:0]  enc_code;
  logic [`ECC_DATA_WIDTH-1:0]  dec_data;
  ecc_code_pkg::ecc_status_e   dec_status;

  logic                        intc_req;
  logic                        intc_we;
  logic [AddrWidth-1:0]        intc_add;
  logic [`ECC_PROT_WIDTH-1:0]  intc_wdata;
  logic [`ECC_PROT_WIDTH-1:0]  intc_rdata;

  assign gnt_o         = (store_state_q == sram_ctrl_pkg::NORMAL);
  assign accept        = req_i && gnt_o;
  assign full_word     = (be_i == '1);
  assign partial_write = accept && !wen_i && !full_word;
  assign word_add      = add_i[AddrWidth+1:2];

  always_comb begin
    store_state_d = store_state_q;
    intc_req      = accept;
    intc_we       = !wen_i && full_word; // Partial writes read first
    intc_add      = word_add;
    case (store_state_q)
      sram_ctrl_pkg::NORMAL: begin
        if (partial_write) begin
          store_state_d = sram_ctrl_pkg::LOAD_AND_STORE;
        end
      end
      sram_ctrl_pkg::LOAD_AND_STORE: begin
        // Old word is on the bank output, write back the merge
        intc_req      = 1'b1;
        intc_we       = 1'b1;
        intc_add      = add_buf_q;
        store_state_d = sram_ctrl_pkg::NORMAL;
      end
      default: store_state_d = sram_ctrl_pkg::NORMAL;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      store_state_q <= sram_ctrl_pkg::NORMAL;
      read_valid_q  <= 1'b0;
    end else begin
      store_state_q <= store_state_d;
      read_valid_q  <= accept && wen_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (partial_write) begin
      add_buf_q   <= word_add;
      be_buf_q    <= be_i;
      wdata_buf_q <= wdata_i;
      mask_buf_q  <= inject_mask_i;
    end
  end

  for (genvar b = 0; b < NumBytes; b++) begin : gen_be_mask
    assign be_mask[8*b +: 8] = {8{be_buf_q[b]}};
  end

  // New bytes over the corrected old word
  assign merged_data = (be_mask & wdata_buf_q) | (~be_mask & dec_data);
  assign enc_data    = (store_state_q == sram_ctrl_pkg::NORMAL) ? wdata_i : merged_data;
  assign intc_wdata  = enc_code ^ ((store_state_q == sram_ctrl_pkg::NORMAL) ?
                                   inject_mask_i : mask_buf_q);

  assign rdata_o        = dec_data;
  assign single_error_o = read_valid_q && (dec_status == ecc_code_pkg::ECC_SINGLE);
  assign multi_error_o  = read_valid_q && (dec_status == ecc_code_pkg::ECC_MULTI);

  hsiao_encoder i_encoder (
    .data_i (enc_data),
    .code_o (enc_code)
  );

  hsiao_decoder i_decoder (
    .code_i     (intc_rdata),
    .data_o     (dec_data),
    .syndrome_o (),
    .status_o   (dec_status)
  );

  ecc_scrubber i_scrubber (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .scrub_trigger_i (scrub_trigger_i),
    .intc_req_i      (intc_req),
    .intc_we_i       (intc_we),
    .intc_add_i      (intc_add),
    .intc_wdata_i    (intc_wdata),
    .bit_corrected_o (scrubber_fix_o),
    .uncorrectable_o (scrub_uncorrectable_o),
    .intc_rdata_o    (intc_rdata)
  );

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   !gnt_o |-> $past(partial_write))
    else $error("grant low without a partial write in the cycle before");

  // The merge goes to the buffered word right after the old one was read
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   partial_write |=>
                   (intc_req && intc_we && (intc_add == $past(word_add))))
    else $error("partial write not followed by its merge write");

endmodule

`default_nettype wire

//--- test/ecc_sram_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "ecc_sram_settings.svh"

module ecc_sram_checker (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       scrub_trigger_i,
  input  logic                       req_i,
  input  logic                       wen_i,
  input  logic [31:0]                add_i,
  input  logic [3:0]                 be_i,
  input  logic [`ECC_DATA_WIDTH-1:0] wdata_i,
  input  logic [`ECC_PROT_WIDTH-1:0] inject_mask_i,
  input  logic [`ECC_DATA_WIDTH-1:0] rdata_i,
  input  logic                       gnt_i,
  input  logic                       single_error_i,
  input  logic                       multi_error_i,
  input  logic                       fix_pulse_i,
  input  logic                       uncorrectable_pulse_i,
  output int                         error_count_o,
  output int                         check_count_o
);

  logic [`ECC_CHECK_WIDTH-1:0] columns [`ECC_DATA_WIDTH];
  logic [`ECC_DATA_WIDTH-1:0]  shadow_data [`ECC_BANK_SIZE];
  logic [`ECC_PROT_WIDTH-1:0]  shadow_code [`ECC_BANK_SIZE]; // Injected flips included
  logic                        read_pending;
  logic [7:0]                  read_word;
  logic                        rmw_pending; // Partial write taken at the last edge
  logic                        trigger_q;
  int                          fixes;
  int                          uncorrectables;

  function automatic logic [`ECC_PROT_WIDTH-1:0] hsiao_encode_ref(
    input logic [`ECC_DATA_WIDTH-1:0] data
  );
    logic [`ECC_CHECK_WIDTH-1:0] chk;
    chk = '0;
    for (int n = 0; n < `ECC_DATA_WIDTH; n++) begin
      if (data[n]) chk = chk ^ columns[n];
    end
    return {chk, data};
  endfunction

  // 0 clean, 1 single flip, 2 double flip (an even syndrome)
  function automatic int classify(input logic [`ECC_PROT_WIDTH-1:0] code);
    logic [`ECC_PROT_WIDTH-1:0] fresh;
    logic [`ECC_CHECK_WIDTH-1:0] syn;
    fresh = hsiao_encode_ref(code[`ECC_DATA_WIDTH-1:0]);
    syn   = fresh[`ECC_PROT_WIDTH-1:`ECC_DATA_WIDTH] ^ code[`ECC_PROT_WIDTH-1:`ECC_DATA_WIDTH];
    if (syn == '0) return 0;
    if ($countones(syn) % 2 == 1) return 1;
    return 2;
  endfunction

  task automatic compare(input string what, input logic [38:0] got, input logic [38:0] expected);
    check_count_o++;
    if (got !== expected) begin
      error_count_o++;
      $display("[FAIL] %s: got %h expected %h at %0t", what, got, expected, $time);
    end
  endtask

  // Every single-flip word gets one fix, every double-flip word one report
  task automatic close_sweep();
    int singles;
    int multis;
    singles = 0;
    multis  = 0;
    for (int w = 0; w < `ECC_BANK_SIZE; w++) begin
      case (classify(shadow_code[w]))
        1: begin
          singles++;
          shadow_code[w] = hsiao_encode_ref(shadow_data[w]); // Repaired by the fix write
        end
        2: multis++;
        default: ;
      endcase
    end
    compare("scrubber_fix_o pulses", 39'(fixes), 39'(singles));
    compare("scrub_uncorrectable_o pulses", 39'(uncorrectables), 39'(multis));
    fixes          = 0;
    uncorrectables = 0;
  endtask

  initial begin
    int idx;
    idx = 0;
    for (int v = 0; v < (1 << `ECC_CHECK_WIDTH); v++) begin
      if ($countones(v) == 3 && idx < `ECC_DATA_WIDTH) begin
        columns[idx] = 7'(v); // Weight-3 patterns in ascending order
        idx++;
      end
    end
    for (int w = 0; w < `ECC_BANK_SIZE; w++) begin
      shadow_data[w] = '0;
      shadow_code[w] = '0;
    end
    error_count_o = 0;
    check_count_o = 0;
  end

  // Inputs and outputs are settled at the falling edge
  always @(negedge clk_i) begin
    logic [`ECC_DATA_WIDTH-1:0] lanes;
    logic [7:0]                 word;
    int                         status;
    if (!rst_ni) begin
      read_pending   = 1'b0;
      rmw_pending    = 1'b0;
      trigger_q      = 1'b0;
      fixes          = 0;
      uncorrectables = 0;
    end else begin
      if (read_pending) begin
        status = classify(shadow_code[read_word]);
        compare("single_error_o", 39'(single_error_i), 39'(status == 1));
        compare("multi_error_o", 39'(multi_error_i), 39'(status == 2));
        if (status != 2) compare("rdata_o", 39'(rdata_i), 39'(shadow_data[read_word]));
      end else begin
        compare("single_error_o without a read", 39'(single_error_i), 39'(0));
        compare("multi_error_o without a read", 39'(multi_error_i), 39'(0));
      end
      compare("gnt_o", 39'(gnt_i), 39'(!rmw_pending));
      fixes          += int'(fix_pulse_i);
      uncorrectables += int'(uncorrectable_pulse_i);
      if (trigger_q && !scrub_trigger_i) close_sweep();
      trigger_q    = scrub_trigger_i;
      read_pending = 1'b0;
      rmw_pending  = 1'b0;
      if (req_i && gnt_i) begin
        word = add_i[9:2];
        if (wen_i) begin
          read_pending = 1'b1;
          read_word    = word;
        end else begin
          lanes = {{8{be_i[3]}}, {8{be_i[2]}}, {8{be_i[1]}}, {8{be_i[0]}}};
          shadow_data[word] = (wdata_i & lanes) | (shadow_data[word] & ~lanes);
          shadow_code[word] = hsiao_encode_ref(shadow_data[word]) ^ inject_mask_i;
          rmw_pending       = (be_i != 4'hf);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tb_ecc_sram.sv
`timescale 1ns/10ps
`default_nettype none

`include "ecc_sram_settings.svh"

module tb_ecc_sram;

  localparam int unsigned NumTraffic  = 300;
  localparam int unsigned NumInject   = 12; // Per injection kind
  localparam int unsigned NumPartial  = 6;
  localparam int unsigned NumSingle   = 5;  // Planted for the scrubber
  localparam int unsigned NumMulti    = 3;
  localparam int unsigned OpCount     = NumTraffic + 4 * NumInject + 5 + 3 * NumPartial +
                                        2 * (NumSingle + NumMulti);
  localparam int unsigned SweepCycles = 2 * `ECC_BANK_SIZE; // Two cycles per clean word
  localparam int unsigned TimeoutNs   = (OpCount * 4 + 3 * `ECC_BANK_SIZE * 4) * 4;

  logic        clk_i;
  logic        rst_ni;
  logic        scrub_trigger_i;
  logic        req_i;
  logic        wen_i;
  logic [31:0] add_i;
  logic [3:0]  be_i;
  logic [31:0] wdata_i;
  logic [38:0] inject_mask_i;
  logic [31:0] rdata_o;
  logic        gnt_o;
  logic        single_error_o;
  logic        multi_error_o;
  logic        scrubber_fix_o;
  logic        scrub_uncorrectable_o;
  int          errors;
  int          checks;
  int          seed;

  always #2 clk_i = ~clk_i;

  ecc_sram_wrap dut_i (.*);

  ecc_sram_checker i_checker (
    .clk_i, .rst_ni, .scrub_trigger_i, .req_i, .wen_i, .add_i, .be_i, .wdata_i,
    .inject_mask_i,
    .rdata_i               (rdata_o),
    .gnt_i                 (gnt_o),
    .single_error_i        (single_error_o),
    .multi_error_i         (multi_error_o),
    .fix_pulse_i           (scrubber_fix_o),
    .uncorrectable_pulse_i (scrub_uncorrectable_o),
    .error_count_o         (errors),
    .check_count_o         (checks)
  );

  // Holds the request until it is granted
  task automatic bus_access(input logic rd, input logic [7:0] word, input logic [3:0] be,
                            input logic [31:0] data, input logic [38:0] mask);
    logic granted;
    req_i         = 1'b1;
    wen_i         = rd;
    add_i         = {22'd0, word, 2'b00};
    be_i          = be;
    wdata_i       = data;
    inject_mask_i = mask;
    granted       = 1'b0;
    while (!granted) begin
      @(negedge clk_i);
      granted = gnt_o;
      @(posedge clk_i);
      #1;
    end
    req_i = 1'b0;
  endtask

  function automatic logic [38:0] two_flips(input int a, input int b);
    return (39'(1) << a) | (39'(1) << b);
  endfunction

  task automatic sweep(input int unsigned cycles);
    scrub_trigger_i = 1'b1;
    repeat (cycles) @(posedge clk_i);
    #1 scrub_trigger_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
  endtask

  initial begin
    int kind;
    int pos;
    logic [31:0] data;
    seed            = 67589;
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    scrub_trigger_i = 1'b0;
    req_i           = 1'b0;
    wen_i           = 1'b0;
    add_i           = '0;
    be_i            = '0;
    wdata_i         = '0;
    inject_mask_i   = '0;
    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(posedge clk_i);
    #1;
    for (int i = 0; i < NumTraffic; i++) begin
      kind = {$random(seed)} % 3;
      data = $random(seed);
      bus_access(kind == 0, 8'({$random(seed)} % 16), (kind == 1) ? 4'hf : 4'($random(seed)),
                 data, '0);
    end
    for (int i = 0; i < NumInject; i++) begin
      pos = {$random(seed)} % 39;
      bus_access(1'b0, 8'd40, 4'hf, $random(seed), 39'(1) << pos);
      bus_access(1'b1, 8'd40, 4'h0, '0, '0);
      pos = {$random(seed)} % 39;
      bus_access(1'b0, 8'd41, 4'hf, $random(seed),
                 two_flips(pos, (pos + 1 + {$random(seed)} % 38) % 39));
      bus_access(1'b1, 8'd41, 4'h0, '0, '0);
    end
    bus_access(1'b0, 8'd40, 4'hf, '0, '0); // Leave no stray errors for the sweep
    bus_access(1'b0, 8'd41, 4'hf, '0, '0);
    for (int i = 0; i < NumPartial; i++) begin
      pos = {$random(seed)} % 39;
      bus_access(1'b0, 8'd42, 4'hf, $random(seed), 39'(1) << pos);
      bus_access(1'b0, 8'd42, 4'(1 + {$random(seed)} % 14), $random(seed), '0);
      bus_access(1'b1, 8'd42, 4'h0, '0, '0);
    end
    pos = {$random(seed)} % 39;
    bus_access(1'b0, 8'd43, 4'h3, $random(seed), 39'(1) << pos); // Flip lands on the merge
    bus_access(1'b1, 8'd43, 4'h0, '0, '0);
    bus_access(1'b0, 8'd43, 4'hf, '0, '0);
    for (int k = 0; k < NumSingle; k++) begin
      pos = {$random(seed)} % 39;
      bus_access(1'b0, 8'(64 + 16 * k), 4'hf, $random(seed), 39'(1) << pos);
    end
    for (int k = 0; k < NumMulti; k++) begin
      pos = {$random(seed)} % 39;
      bus_access(1'b0, 8'(200 + 8 * k), 4'hf, $random(seed),
                 two_flips(pos, (pos + 1 + {$random(seed)} % 38) % 39));
    end
    sweep(SweepCycles + NumSingle); // Each fix costs one extra cycle
    sweep(SweepCycles);
    for (int k = 0; k < NumSingle; k++) bus_access(1'b1, 8'(64 + 16 * k), 4'h0, '0, '0);
    for (int k = 0; k < NumMulti; k++) bus_access(1'b1, 8'(200 + 8 * k), 4'h0, '0, '0);
    repeat (4) @(posedge clk_i);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(TimeoutNs);
    $display("Watchdog expired after %0d ns before the stimulus finished", TimeoutNs);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- ecc_sram_wrap.f
+incdir+logic
logic/ecc_code_pkg.sv
logic/sram_ctrl_pkg.sv
logic/hsiao_encoder.sv
logic/hsiao_decoder.sv
logic/sram_bank.sv
logic/ecc_scrubber.sv
logic/ecc_sram_wrap.sv
test/ecc_sram_checker.sv
test/tb_ecc_sram.sv

//--- run.sh
#!/bin/sh
# Build and run the ECC SRAM testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ecc_sram \
  -f ecc_sram_wrap.f -o sim_ecc_sram

./obj_dir/sim_ecc_sram | tee sim.log

if grep -q "test failed" sim.log; then
  exit 1
fi
grep -q "test passed" sim.log
